/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# verdict comes from the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/bank_crossbar.sv */
`timescale 1ns/1ns

module bank_crossbar import cache_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  cpu_req_t cpu_req  [NUM_PORTS],
    output cpu_rsp_t cpu_rsp  [NUM_PORTS],
    output cpu_req_t bank_req [NUM_BANKS],
    input  cpu_rsp_t bank_rsp [NUM_BANKS]
);

    // per port decode
    logic [NUM_PORTS-1:0] port_present;
    logic [BANK_W-1:0]    port_bank [NUM_PORTS];

    // per bank request vector, one bit per port
    logic [NUM_PORTS-1:0] want [NUM_BANKS];

    // grant state per bank
    logic [NUM_BANKS-1:0] busy;
    logic [NUM_BANKS-1:0] owner;
    // port favored on the next conflict
    logic [NUM_BANKS-1:0] prio;

    // effective grant this cycle
    logic [NUM_BANKS-1:0] gnt_valid;
    logic [NUM_BANKS-1:0] gnt_port;
    logic [NUM_BANKS-1:0] done;

    // bank select decode
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_present[p] = cpu_req[p].read | cpu_req[p].write;
            port_bank[p]    = cpu_req[p].addr[OFFSET_W +: BANK_W];
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                want[b][p] = port_present[p] && (port_bank[p] == BANK_W'(b));
            end
        end
    end

    // grant per bank
    // a held grant wins, otherwise a fresh one is taken this cycle
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            gnt_valid[b] = 1'b0;
            gnt_port[b]  = 1'b0;
            if (busy[b]) begin
                gnt_valid[b] = 1'b1;
                gnt_port[b]  = owner[b];
            end else if (&want[b]) begin
                // conflict, round robin
                gnt_valid[b] = 1'b1;
                gnt_port[b]  = prio[b];
            end else if (want[b][0]) begin
                gnt_valid[b] = 1'b1;
                gnt_port[b]  = 1'b0;
            end else if (want[b][1]) begin
                gnt_valid[b] = 1'b1;
                gnt_port[b]  = 1'b1;
            end
            // bank finishes when busywait drops under a granted request
            done[b] = gnt_valid[b] && !bank_rsp[b].busywait;
        end
    end

    // forward the granted request, idle banks see nothing
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (gnt_valid[b]) begin
                bank_req[b] = cpu_req[gnt_port[b]];
            end else begin
                bank_req[b] = '0;
            end
        end
    end

    // return path
    // losers and waiting ports stay in busywait
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            cpu_rsp[p].busywait = port_present[p];
            cpu_rsp[p].readdata = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (gnt_valid[b] && (gnt_port[b] == 1'(p)) && want[b][p]) begin
                    cpu_rsp[p] = bank_rsp[b];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= '0;
            owner <= '0;
            prio  <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (done[b]) begin
                    // release, other port goes first next time
                    busy[b] <= 1'b0;
                    prio[b] <= ~gnt_port[b];
                end else if (gnt_valid[b]) begin
                    busy[b]  <= 1'b1;
                    owner[b] <= gnt_port[b];
                end
            end
        end
    end

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

    // cpu side of the cache
    localparam int NUM_PORTS = 2;
    localparam int NUM_BANKS = 4;

    // byte address geometry
    localparam int ADDR_W   = 10;
    localparam int OFFSET_W = 2;
    // bank select sits in addr[3:2]
    localparam int BANK_W   = 2;
    // set index sits in addr[6:4]
    localparam int INDEX_W  = 3;
    // tag sits in addr[9:7]
    localparam int TAG_W    = 3;

    // derived sizes
    localparam int BYTE_W   = 8;
    localparam int NUM_SETS = 2 ** INDEX_W;

    // cpu or bank request
    // read and write are never set together
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] writedata;
    } cpu_req_t;

    // cpu or bank response
    // readdata only meaningful in the completion cycle of a read
    typedef struct packed {
        logic              busywait;
        logic [BYTE_W-1:0] readdata;
    } cpu_rsp_t;

endpackage

/* design/dcache_bank.sv */
`timescale 1ns/1ns

module dcache_bank import cache_pkg::*; import mem_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  cpu_req_t req,
    output cpu_rsp_t rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        state_idle,
        state_lookup,
        state_writeback,
        state_refill
    } state_t;

    state_t state;
    state_t state_next;

    // line status, cleared on reset
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    // tag and data arrays
    logic [TAG_W-1:0]  tag_mem  [NUM_SETS];
    logic [WORD_W-1:0] line_mem [NUM_SETS];

    // request fields
    logic                present;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [BANK_W-1:0]   bank_sel;
    logic [OFFSET_W-1:0] offset;

    logic hit;
    logic write_hit;

    assign present  = req.read | req.write;
    assign tag      = req.addr[ADDR_W-1 -: TAG_W];
    assign index    = req.addr[OFFSET_W + BANK_W +: INDEX_W];
    // bank bits of a routed request always name this bank
    assign bank_sel = req.addr[OFFSET_W +: BANK_W];
    assign offset   = req.addr[OFFSET_W-1:0];

    // tag compare
    assign hit       = valid_bits[index] && (tag_mem[index] == tag);
    assign write_hit = (state == state_lookup) && hit && req.write;

    // completion only in lookup on a hit
    assign rsp.busywait = present && !((state == state_lookup) && hit);
    // byte select from the indexed line
    assign rsp.readdata = line_mem[index][BYTE_W*offset +: BYTE_W];

    // next state
    always_comb begin
        state_next = state;
        case (state)
            state_idle: begin
                if (present) begin
                    state_next = state_lookup;
                end
            end
            state_lookup: begin
                if (!present || hit) begin
                    state_next = state_idle;
                end else if (valid_bits[index] && dirty_bits[index]) begin
                    // old line must go out first
                    state_next = state_writeback;
                end else begin
                    state_next = state_refill;
                end
            end
            state_writeback: begin
                if (mem_rsp.done) begin
                    state_next = state_refill;
                end
            end
            state_refill: begin
                // back to lookup, which then hits
                if (mem_rsp.done) begin
                    state_next = state_lookup;
                end
            end
            default: state_next = state_idle;
        endcase
    end

    // memory side
    always_comb begin
        mem_req = '0;
        case (state)
            state_writeback: begin
                // victim goes to the address of its own tag
                mem_req.write     = 1'b1;
                mem_req.addr      = {tag_mem[index], index, bank_sel};
                mem_req.writedata = line_mem[index];
            end
            state_refill: begin
                mem_req.read = 1'b1;
                mem_req.addr = {tag, index, bank_sel};
            end
            default: mem_req = '0;
        endcase
    end

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= state_idle;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            state <= state_next;
            if (state == state_refill && mem_rsp.done) begin
                // fresh line is clean
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;
            end else if (state == state_writeback && mem_rsp.done) begin
                dirty_bits[index] <= 1'b0;
            end else if (write_hit) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    // tag and line payload
    always_ff @(posedge clock) begin
        if (state == state_refill && mem_rsp.done) begin
            tag_mem[index]  <= tag;
            line_mem[index] <= mem_rsp.readdata;
        end else if (write_hit) begin
            // byte merge
            line_mem[index][BYTE_W*offset +: BYTE_W] <= req.writedata;
        end
    end

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top import cache_pkg::*; import mem_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  cpu_req_t cpu_req [NUM_PORTS],
    output cpu_rsp_t cpu_rsp [NUM_PORTS],
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // crossbar to banks
    cpu_req_t bank_req [NUM_BANKS];
    cpu_rsp_t bank_rsp [NUM_BANKS];

    // banks to memory arbiter
    mem_req_t bank_mem_req [NUM_BANKS];
    mem_rsp_t bank_mem_rsp [NUM_BANKS];

    bank_crossbar crossbar_i (
        .clock    (clock),
        .reset    (reset),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .bank_req (bank_req),
        .bank_rsp (bank_rsp)
    );

    // one bank per bank select value
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dcache_bank bank_i (
            .clock   (clock),
            .reset   (reset),
            .req     (bank_req[b]),
            .rsp     (bank_rsp[b]),
            .mem_req (bank_mem_req[b]),
            .mem_rsp (bank_mem_rsp[b])
        );
    end

    // single shared memory port
    mem_arbiter arbiter_i (
        .clock        (clock),
        .reset        (reset),
        .bank_mem_req (bank_mem_req),
        .bank_mem_rsp (bank_mem_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter import cache_pkg::*; import mem_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t bank_mem_req [NUM_BANKS],
    output mem_rsp_t bank_mem_rsp [NUM_BANKS],
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // transaction in flight
    logic              busy;
    logic [BANK_W-1:0] owner;
    // last bank granted, search starts after it
    logic [BANK_W-1:0] last;

    logic [NUM_BANKS-1:0] pending;
    logic [BANK_W-1:0]    cand;
    logic [BANK_W-1:0]    sel;
    logic                 sel_valid;

    // pick one bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            pending[b] = bank_mem_req[b].read | bank_mem_req[b].write;
        end
        sel       = owner;
        sel_valid = busy;
        cand      = last;
        if (!busy) begin
            // round robin from the bank after the last winner
            for (int k = 1; k <= NUM_BANKS; k++) begin
                cand = last + BANK_W'(k);
                if (!sel_valid && pending[cand]) begin
                    sel       = cand;
                    sel_valid = 1'b1;
                end
            end
        end
    end

    // forward the granted transaction
    assign mem_req = sel_valid ? bank_mem_req[sel] : '0;

    // done goes only to the granted bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_mem_rsp[b].done     = sel_valid && (sel == BANK_W'(b)) && mem_rsp.done;
            bank_mem_rsp[b].readdata = mem_rsp.readdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= '0;
            // first search starts at bank 0
            last  <= '1;
        end else begin
            // hold until done, done on the grant cycle frees at once
            busy <= sel_valid && !mem_rsp.done;
            if (sel_valid) begin
                owner <= sel;
            end
            if (sel_valid && !busy) begin
                last <= sel;
            end
        end
    end

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

    // one line is one memory word
    localparam int WORD_W     = 32;

    // word address is {tag, index, bank}
    localparam int MEM_ADDR_W = 8;

    // memory transaction
    // present while read or write is set, held until done
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [MEM_ADDR_W-1:0] addr;
        logic [WORD_W-1:0]     writedata;
    } mem_req_t;

    // memory completion
    // readdata valid only with done
    typedef struct packed {
        logic              done;
        logic [WORD_W-1:0] readdata;
    } mem_rsp_t;

endpackage

/* flist.f */
design/cache_pkg.sv
design/mem_pkg.sv
design/bank_crossbar.sv
design/dcache_bank.sv
design/mem_arbiter.sv
design/dcache_top.sv
test/dcache_assertions.sv
test/dcache_tb.sv

/* test/dcache_assertions.sv */
`timescale 1ns/1ns

module dcache_assertions import cache_pkg::*, mem_pkg::*; (
    input logic     clock,
    input logic     reset,
    input cpu_req_t cpu_req  [NUM_PORTS],
    input cpu_rsp_t cpu_rsp  [NUM_PORTS],
    input cpu_req_t bank_req [NUM_BANKS],
    input cpu_rsp_t bank_rsp [NUM_BANKS],
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp
);

    // number of failed checks
    int failures = 0;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // port request held while busywait
        assert property (@(posedge clock) disable iff (reset)
            (cpu_req[p].read || cpu_req[p].write) && cpu_rsp[p].busywait
            |=> $stable(cpu_req[p]))
        else begin
            $error("cpu_req[%0d] changed while busywait was high", p);
            failures++;
        end
        // idle port never waits
        assert property (@(posedge clock) disable iff (reset)
            !(cpu_req[p].read || cpu_req[p].write) |-> !cpu_rsp[p].busywait)
        else begin
            $error("cpu_rsp[%0d].busywait high with no request", p);
            failures++;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // bank request held until the bank completes
        assert property (@(posedge clock) disable iff (reset)
            (bank_req[b].read || bank_req[b].write) && bank_rsp[b].busywait
            |=> $stable(bank_req[b]))
        else begin
            $error("bank_req[%0d] changed while busywait was high", b);
            failures++;
        end
    end

    // memory transaction held until done
    assert property (@(posedge clock) disable iff (reset)
        (mem_req.read || mem_req.write) && !mem_rsp.done |=> $stable(mem_req))
    else begin
        $error("mem_req changed before done");
        failures++;
    end

    assert property (@(posedge clock) disable iff (reset) !(mem_req.read && mem_req.write))
    else begin
        $error("mem_req read and write both set");
        failures++;
    end

endmodule

bind dcache_top dcache_assertions assertions_i (.*);

/* test/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb import cache_pkg::*, mem_pkg::*; ();

    // run length, memory latency and lfsr seed
    localparam int          NUM_OPS        = 400;
    localparam int          RESET_CYCLES   = 16;
    localparam int          MEM_LAT_MAX    = 4;
    localparam logic [15:0] SEED           = 16'd92;
    // worst op waits behind every port and bank for two transactions plus completion each
    localparam int          OP_BOUND       = NUM_PORTS * NUM_BANKS * (2 * MEM_LAT_MAX + 1);
    localparam int          TIMEOUT_CYCLES = NUM_OPS * OP_BOUND + RESET_CYCLES + 200;

    logic     clock = 1'b0;
    logic     reset = 1'b1;
    cpu_req_t cpu_req [NUM_PORTS];
    cpu_rsp_t cpu_rsp [NUM_PORTS];
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // backing memory and byte model owned by the sampler
    logic [WORD_W-1:0] memory [2**MEM_ADDR_W];
    logic [BYTE_W-1:0] model  [2**ADDR_W];

    logic [15:0] lfsr;
    logic        started;
    logic        hold_memory;
    int          mem_wait;
    int          cycles          = 0;
    int          read_errors     = 0;
    int          write_errors    = 0;
    int          protocol_errors = 0;
    int          sequence_errors = 0;
    // per port bookkeeping
    logic        pending       [NUM_PORTS];
    int          gap           [NUM_PORTS];
    int          random_issued [NUM_PORTS];
    int          retired       [NUM_PORTS];
    int          completions   [NUM_PORTS] = '{default: 0};

    dcache_top dut_i (
        .clock   (clock),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit taken
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // each byte depends on the whole word address
    function automatic logic [WORD_W-1:0] fill_word(input logic [MEM_ADDR_W-1:0] a);
        return {a ^ 8'hc3, a + 8'h5a, ~a, a * 8'd7};
    endfunction

    function automatic logic [WORD_W-1:0] model_word(input logic [MEM_ADDR_W-1:0] a);
        return {model[{a, 2'd3}], model[{a, 2'd2}], model[{a, 2'd1}], model[{a, 2'd0}]};
    endfunction

    // refill needs a port on that word and writeback a port on that bank and set
    function automatic logic has_owner(input mem_req_t req);
        logic found;
        found = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (cpu_req[p].read || cpu_req[p].write) begin
                found = found | (req.read && cpu_req[p].addr[ADDR_W-1:OFFSET_W] == req.addr);
                found = found | (req.write && cpu_req[p].addr[6:OFFSET_W] == req.addr[4:0]);
            end
        end
        return found;
    endfunction

    task automatic load_memory();
        logic [WORD_W-1:0] word;
        for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
            word      = fill_word(MEM_ADDR_W'(a));
            memory[a] = word;
            for (int k = 0; k < 4; k++) begin
                model[4*a+k] = word[8*k +: 8];
            end
        end
    endtask

    task automatic compare_read(input int port, input logic [ADDR_W-1:0] addr,
                                input cpu_rsp_t rsp, input logic [BYTE_W-1:0] expected);
        if (rsp.readdata !== expected) begin
            read_errors++;
            $display("error cpu_rsp[%0d].readdata addr 0x%03h got 0x%02h expected 0x%02h",
                     port, addr, rsp.readdata, expected);
        end
    endtask

    task automatic compare_mem_write(input mem_req_t req, input logic [WORD_W-1:0] expected);
        if (req.writedata !== expected) begin
            write_errors++;
            $display("error mem_req.writedata addr 0x%02h got 0x%08h expected 0x%08h",
                     req.addr, req.writedata, expected);
        end
    endtask

    task automatic report_counts();
        $display("errors read %0d, memory write %0d, protocol %0d, sequence %0d, assertion %0d",
                 read_errors, write_errors, protocol_errors, sequence_errors,
                 dut_i.assertions_i.failures);
    endtask

    // inputs change on the falling edge so the rising edge sees them stable
    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("TEST FAIL");
            $finish;
        end else if (reset) begin
            load_memory();
        end else begin
            if (!started && (cpu_rsp[0].busywait || cpu_rsp[1].busywait
                             || mem_req.read || mem_req.write)) begin
                protocol_errors++;
                $display("busywait or a memory request was active before the first request");
            end
            if ((mem_req.read || mem_req.write) && mem_rsp.done) begin
                if (!has_owner(mem_req)) begin
                    protocol_errors++;
                    $display("error mem_req.addr 0x%02h matches no waiting request", mem_req.addr);
                end
                if (mem_req.write) begin
                    compare_mem_write(mem_req, model_word(mem_req.addr));
                    memory[mem_req.addr] = mem_req.writedata;
                end
            end
            // completion is a present request with busywait low
            for (int p = 0; p < NUM_PORTS; p++) begin
                if ((cpu_req[p].read || cpu_req[p].write) && !cpu_rsp[p].busywait) begin
                    if (cpu_req[p].read) begin
                        compare_read(p, cpu_req[p].addr, cpu_rsp[p], model[cpu_req[p].addr]);
                    end else begin
                        model[cpu_req[p].addr] = cpu_req[p].writedata;
                    end
                    completions[p]++;
                end
            end
        end
    end

    // done pulses for one cycle after 1 to 4 cycles unless held
    task automatic serve_memory();
        if (mem_rsp.done) begin
            mem_rsp = '0;
        end else if (mem_req.read || mem_req.write) begin
            if (mem_wait < 0) begin
                mem_wait = int'(random_bits(2));
            end
            if (mem_wait > 0) begin
                mem_wait--;
            end else if (!hold_memory) begin
                mem_rsp.done     = 1'b1;
                mem_rsp.readdata = memory[mem_req.addr];
                mem_wait         = -1;
            end
        end
    endtask

    task automatic start_op(input int p, input logic rd, input logic [ADDR_W-1:0] addr,
                            input logic [BYTE_W-1:0] data);
        cpu_req[p].read      = rd;
        cpu_req[p].write     = !rd;
        cpu_req[p].addr      = addr;
        cpu_req[p].writedata = data;
        pending[p]           = 1'b1;
        started              = 1'b1;
    endtask

    // drop requests that completed at the last edge
    task automatic retire_ports();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (pending[p] && completions[p] != retired[p]) begin
                retired[p]++;
                pending[p] = 1'b0;
                cpu_req[p] = '0;
            end
        end
    endtask

    task automatic issue_random();
        logic                rd;
        logic [ADDR_W-1:0]   addr;
        logic [BYTE_W-1:0]   data;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!pending[p] && random_issued[p] < NUM_OPS) begin
                if (gap[p] > 0) begin
                    gap[p]--;
                end else begin
                    rd   = 1'(random_bits(1));
                    addr = ADDR_W'(random_bits(ADDR_W));
                    data = BYTE_W'(random_bits(BYTE_W));
                    start_op(p, rd, addr, data);
                    random_issued[p]++;
                    gap[p] = int'(random_bits(2));
                end
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge clock);
        serve_memory();
        retire_ports();
    endtask

    task automatic wait_port(input int p);
        while (pending[p]) begin
            step_cycle();
        end
    endtask

    // bank 2 stalls on memory while bank 1 keeps serving hits
    task automatic check_stall_bypass();
        int n;
        start_op(1, 1'b1, 10'h014, 8'h00);
        wait_port(1);
        hold_memory = 1'b1;
        start_op(0, 1'b1, 10'h0a8, 8'h00);
        step_cycle();
        start_op(1, 1'b1, 10'h017, 8'h00);
        n = 0;
        while (pending[1] && n < OP_BOUND) begin
            step_cycle();
            n++;
        end
        if (pending[1] || !pending[0]) begin
            sequence_errors++;
            $display("a hit in bank 1 did not complete while bank 2 waited on memory");
        end
        hold_memory = 1'b0;
        wait_port(0);
        wait_port(1);
    endtask

    initial begin
        lfsr        = SEED;
        started     = 1'b0;
        hold_memory = 1'b0;
        mem_wait    = -1;
        mem_rsp     = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cpu_req[p]       = '0;
            pending[p]       = 1'b0;
            gap[p]           = 0;
            random_issued[p] = 0;
            retired[p]       = 0;
        end
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        // quiet cycles checked by the sampler
        repeat (4) @(negedge clock);
        check_stall_bypass();
        while (random_issued[0] < NUM_OPS || random_issued[1] < NUM_OPS
               || pending[0] || pending[1]) begin
            step_cycle();
            issue_random();
        end
        report_counts();
        if (read_errors + write_errors + protocol_errors + sequence_errors
            + dut_i.assertions_i.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
